// ==== icache_trace.txt ====
# op addr refill, op F fetch, B bypass on, U bypass off, X flush pulse
# addr in hex, refill 1 when the fetch must go to the refill memory
F 00001030 1
F 0000103c 0
F 00002030 1
F 00001030 0
F 00002038 0
F 00003030 1
F 00002030 0
F 00001030 1
F 00003030 0
F 00002030 1
F 00001030 0
F 00005050 1
F 00003030 1
F 00001030 0
F 00002030 1
F 00005050 0
X 00000000 0
F 00003030 1
F 00005050 1
F 00003030 0
B 00000000 0
F 000070a0 1
F 000070a4 1
F 00003030 1
U 00000000 0
F 000070a0 1
F 000070a0 0
F 00003030 0
F 00009030 1
F 0000a030 1
F 00003030 1
F 0000a030 0
F 00009030 1
F 00003030 0

// ==== files.f ====
icache_cfg_pkg.sv
icache_bus_pkg.sv
icache_way_bank.sv
icache_tag_compare.sv
icache_refill_fifo.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - icache_cfg_pkg.sv
      - icache_bus_pkg.sv
      - icache_way_bank.sv
      - icache_tag_compare.sv
      - icache_refill_fifo.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    files:
      - tb_icache.sv

// ==== tb_icache.sv ====
////////////////////////////////////////
// Replays icache_trace.txt against a refill memory with random delays
// Run from the project root so the trace file is found
////////////////////////////////////////

`timescale 1ns/1ps

module tb_icache;

   import icache_cfg_pkg::*;
   import icache_bus_pkg::*;

   localparam int unsigned CLK_PERIOD = 40;
   localparam int unsigned IN_DELAY   = 2;     // Input skew after the rising edge

   logic        clk;
   logic        arst_n_i;
   logic        fetch_req_i;
   fetch_addr_t fetch_addr_i;
   logic        fetch_gnt_o;
   logic        fetch_rvalid_o;
   line_t       fetch_rdata_o;
   logic        refill_req_o;
   logic        refill_gnt_i;
   refill_req_t refill_addr_o;
   logic        refill_r_valid_i;
   line_t       refill_r_data_i;
   logic        bypass_icache_i;
   logic        cache_is_bypassed_o;
   logic        flush_icache_i;
   logic        cache_is_flushed_o;

   integer      seed = 32'h82db_9009;
   int          refill_cnt;                // Refills granted by the memory model
   fetch_addr_t line_addr_exp;             // Line of the fetch in flight
   int          cycle_cnt;
   int          cycle_limit = 0;
   bit          first_fetch = 1'b1;

   // Trace rows
   byte         op_q[$];
   fetch_addr_t addr_q[$];
   bit          refill_q[$];

   icache_top dut0 (
      .clk                 ( clk                 ),
      .arst_n_i            ( arst_n_i            ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_r_valid_i    ( refill_r_valid_i    ),
      .refill_r_data_i     ( refill_r_data_i     ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  )
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // Memory content is the line address in every word with the word number in bits 1:0
   function automatic line_t line_of(input fetch_addr_t addr);
      fetch_addr_t base;
      base = {addr[FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      return {base | 32'd3, base | 32'd2, base | 32'd1, base};
   endfunction

   task automatic stop_on_failure(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first failure");
   endtask

   task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                              input logic [LINE_W-1:0] exp);
      if (got !== exp)
      begin
         stop_on_failure($sformatf("error at %0t: %s is %0h, expected %0h",
                                   $time, name, got, exp));
      end
   endtask

   // One fetch whose request stays up until the response to catch a second grant
   task automatic do_fetch(input fetch_addr_t addr, input bit exp_refill);
      int refills_before;
      int latency;
      @(posedge clk);
      #IN_DELAY;
      refills_before = refill_cnt;
      line_addr_exp  = {addr[FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      fetch_req_i    = 1'b1;
      fetch_addr_i   = addr;
      @(negedge clk);
      while (fetch_gnt_o !== 1'b1)
      begin
         @(negedge clk);                  // Held off during a flush walk
      end
      if (first_fetch)
      begin
         check_value("cache_is_flushed_o", cache_is_flushed_o, 1'b1);
         first_fetch = 1'b0;
      end
      latency = 0;
      do
      begin
         @(negedge clk);
         latency++;
         check_value("fetch_gnt_o", fetch_gnt_o, 1'b0);   // One fetch in flight
      end
      while (fetch_rvalid_o !== 1'b1);
      check_value("fetch_rdata_o", fetch_rdata_o, line_of(addr));
      check_value("refill count", refill_cnt - refills_before, exp_refill);
      if (!exp_refill)
      begin
         check_value("hit latency", latency, 1);          // Data one cycle after grant
      end
      @(posedge clk);
      #IN_DELAY;
      fetch_req_i = 1'b0;
   endtask

   task automatic do_flush();
      @(posedge clk);
      #IN_DELAY;
      flush_icache_i = 1'b1;
      @(posedge clk);
      #IN_DELAY;
      flush_icache_i = 1'b0;
      @(negedge clk);
      check_value("cache_is_flushed_o", cache_is_flushed_o, 1'b0);   // Walk started
      while (cache_is_flushed_o !== 1'b1)
      begin
         @(negedge clk);
      end
   endtask

   task automatic set_bypass(input bit on);
      @(posedge clk);
      #IN_DELAY;
      bypass_icache_i = on;
      @(negedge clk);
      check_value("cache_is_bypassed_o", cache_is_bypassed_o, on);
   endtask

   ////////////////////////////////////////
   // Refill memory model
   ////////////////////////////////////////

   initial
   begin : refill_memory
      int          gnt_delay;
      int          rsp_delay;
      refill_req_t req_addr;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      refill_cnt       = 0;
      forever
      begin
         @(negedge clk);
         if (refill_req_o === 1'b1)
         begin
            req_addr  = refill_addr_o;
            check_value("refill_addr_o", req_addr, line_addr_exp);
            gnt_delay = $unsigned($random(seed)) % 4;
            rsp_delay = $unsigned($random(seed)) % 4;
            repeat (gnt_delay)
            begin
               @(negedge clk);
               check_value("refill_req_o", refill_req_o, 1'b1);    // Held until granted
            end
            @(posedge clk);
            #IN_DELAY;
            refill_gnt_i = 1'b1;
            @(posedge clk);
            #IN_DELAY;
            refill_gnt_i = 1'b0;
            refill_cnt++;
            repeat (rsp_delay)
            begin
               @(posedge clk);
               #IN_DELAY;
            end
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = line_of(req_addr);
            @(posedge clk);
            #IN_DELAY;
            refill_r_valid_i = 1'b0;
         end
      end
   end

   // Cycle budget from the trace length
   initial
   begin : watchdog
      cycle_cnt = 0;
      @(posedge clk);
      while ((cycle_limit == 0) || (cycle_cnt < cycle_limit))
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      stop_on_failure($sformatf("timeout, the run did not end within %0d cycles", cycle_limit));
   end

   ////////////////////////////////////////
   // Trace replay
   ////////////////////////////////////////

   initial
   begin : main
      integer      fd;
      int          c;
      int          code;
      fetch_addr_t addr;
      int          flag;
      arst_n_i        = 1'b0;
      fetch_req_i     = 1'b0;
      fetch_addr_i    = '0;
      bypass_icache_i = 1'b0;
      flush_icache_i  = 1'b0;

      fd = $fopen("icache_trace.txt", "r");
      if (fd == 0)
      begin
         stop_on_failure("could not open icache_trace.txt");
      end
      c = $fgetc(fd);
      while (c != -1)
      begin
         if (c == "#")
         begin
            while ((c != "\n") && (c != -1))
            begin
               c = $fgetc(fd);                          // Skip comment line
            end
         end
         else if ((c == "F") || (c == "B") || (c == "U") || (c == "X"))
         begin
            code = $fscanf(fd, "%h %d", addr, flag);
            if (code != 2)
            begin
               stop_on_failure("malformed row in icache_trace.txt");
            end
            op_q.push_back(byte'(c));
            addr_q.push_back(addr);
            refill_q.push_back(flag != 0);
         end
         else if (c > " ")
         begin
            stop_on_failure("unknown operation in icache_trace.txt");
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
      cycle_limit = op_q.size() * 40 + 200;

      repeat (10) @(posedge clk);
      #IN_DELAY;
      arst_n_i = 1'b1;

      for (int i = 0; i < op_q.size(); i++)
      begin
         case (op_q[i])
            "F":     do_fetch(addr_q[i], refill_q[i]);
            "B":     set_bypass(1'b1);
            "U":     set_bypass(1'b0);
            default: do_flush();
         endcase
      end

      repeat (4) @(posedge clk);
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== icache_top.sv ====
////////////////////////////////////////
// Private instruction cache, one fetch port, one refill port
////////////////////////////////////////

`timescale 1ns/1ps

module icache_top (
   input  logic                        clk,
   input  logic                        arst_n_i,
   input  logic                        fetch_req_i,
   input  icache_cfg_pkg::fetch_addr_t fetch_addr_i,
   output logic                        fetch_gnt_o,
   output logic                        fetch_rvalid_o,
   output icache_cfg_pkg::line_t       fetch_rdata_o,
   output logic                        refill_req_o,
   input  logic                        refill_gnt_i,
   output icache_bus_pkg::refill_req_t refill_addr_o,
   input  logic                        refill_r_valid_i,
   input  icache_cfg_pkg::line_t       refill_r_data_i,
   input  logic                        bypass_icache_i,
   output logic                        cache_is_bypassed_o,
   input  logic                        flush_icache_i,
   output logic                        cache_is_flushed_o
);

   import icache_cfg_pkg::*;
   import icache_bus_pkg::*;

   way_access_t                tag_acc;
   way_access_t                data_acc;
   tag_entry_t                 tag_wdata;
   line_t                      data_wdata;
   tag_entry_t [NB_WAYS-1:0]   tag_rdata;
   line_t      [NB_WAYS-1:0]   data_rdata;
   way_vec_t                   tag_rd_en, tag_wr_en;
   way_vec_t                   data_rd_en, data_wr_en;
   tag_t                       fetch_tag;
   logic                       hit;
   way_vec_t                   hit_way, victim_way;
   logic                       refill_done;
   logic                       resp_valid;      // Buffered refill response
   line_t                      resp_data;

   icache_ctrl i_ctrl (
      .clk                 ( clk                 ),
      .arst_n_i            ( arst_n_i            ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .tag_acc_o           ( tag_acc             ),
      .tag_wdata_o         ( tag_wdata           ),
      .data_acc_o          ( data_acc            ),
      .data_wdata_o        ( data_wdata          ),
      .data_rdata_i        ( data_rdata          ),
      .fetch_tag_o         ( fetch_tag           ),
      .hit_i               ( hit                 ),
      .hit_way_i           ( hit_way             ),
      .victim_way_i        ( victim_way          ),
      .refill_done_o       ( refill_done         ),
      .refill_req_o        ( refill_req_o        ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_addr_o       ( refill_addr_o       ),
      .resp_valid_i        ( resp_valid          ),
      .resp_data_i         ( resp_data           ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  )
   );

   icache_tag_compare i_tag_compare (
      .clk           ( clk         ),
      .arst_n_i      ( arst_n_i    ),
      .tags_i        ( tag_rdata   ),
      .fetch_tag_i   ( fetch_tag   ),
      .refill_done_i ( refill_done ),
      .hit_o         ( hit         ),
      .hit_way_o     ( hit_way     ),
      .victim_way_o  ( victim_way  )
   );

   icache_refill_fifo i_refill_fifo (
      .clk      ( clk              ),
      .arst_n_i ( arst_n_i         ),
      .push_i   ( refill_r_valid_i ),
      .data_i   ( refill_r_data_i  ),
      .valid_o  ( resp_valid       ),
      .data_o   ( resp_data        )
   );

   ////////////////////////////////////////
   // Tag banks
   ////////////////////////////////////////

   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_tag_way
      assign tag_rd_en[w] = tag_acc.req[w] & ~tag_acc.we;
      assign tag_wr_en[w] = tag_acc.req[w] &  tag_acc.we;

      icache_way_bank #(
         .WIDTH ( $bits(tag_entry_t) ),
         .DEPTH ( NB_SETS            )
      ) i_tag_bank (
         .clk      ( clk          ),
         .arst_n_i ( arst_n_i     ),
         .rd_en_i  ( tag_rd_en[w] ),
         .wr_en_i  ( tag_wr_en[w] ),
         .addr_i   ( tag_acc.idx  ),
         .wdata_i  ( tag_wdata    ),
         .rdata_o  ( tag_rdata[w] )
      );
   end

   ////////////////////////////////////////
   // Data banks
   ////////////////////////////////////////

   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_data_way
      assign data_rd_en[w] = data_acc.req[w] & ~data_acc.we;
      assign data_wr_en[w] = data_acc.req[w] &  data_acc.we;

      icache_way_bank #(
         .WIDTH ( LINE_W  ),
         .DEPTH ( NB_SETS )
      ) i_data_bank (
         .clk      ( clk           ),
         .arst_n_i ( arst_n_i      ),
         .rd_en_i  ( data_rd_en[w] ),
         .wr_en_i  ( data_wr_en[w] ),
         .addr_i   ( data_acc.idx  ),
         .wdata_i  ( data_wdata    ),
         .rdata_o  ( data_rdata[w] )
      );
   end

endmodule

// ==== icache_ctrl.sv ====
////////////////////////////////////////
// One fetch in flight, no new grant until its response
// Flush pulses seen during a miss are served once back in IDLE
////////////////////////////////////////

`timescale 1ns/1ps

module icache_ctrl (
   input  logic                                               clk,
   input  logic                                               arst_n_i,
   input  logic                                               fetch_req_i,
   input  icache_cfg_pkg::fetch_addr_t                        fetch_addr_i,
   output logic                                               fetch_gnt_o,
   output logic                                               fetch_rvalid_o,
   output icache_cfg_pkg::line_t                              fetch_rdata_o,
   output icache_bus_pkg::way_access_t                        tag_acc_o,
   output icache_cfg_pkg::tag_entry_t                         tag_wdata_o,
   output icache_bus_pkg::way_access_t                        data_acc_o,
   output icache_cfg_pkg::line_t                              data_wdata_o,
   input  icache_cfg_pkg::line_t [icache_cfg_pkg::NB_WAYS-1:0] data_rdata_i,
   output icache_cfg_pkg::tag_t                               fetch_tag_o,
   input  logic                                               hit_i,
   input  icache_cfg_pkg::way_vec_t                           hit_way_i,
   input  icache_cfg_pkg::way_vec_t                           victim_way_i,
   output logic                                               refill_done_o,
   output logic                                               refill_req_o,
   input  logic                                               refill_gnt_i,
   output icache_bus_pkg::refill_req_t                        refill_addr_o,
   input  logic                                               resp_valid_i,
   input  icache_cfg_pkg::line_t                              resp_data_i,
   input  logic                                               bypass_icache_i,
   output logic                                               cache_is_bypassed_o,
   input  logic                                               flush_icache_i,
   output logic                                               cache_is_flushed_o
);

   import icache_cfg_pkg::*;
   import icache_bus_pkg::*;

   ctrl_state_e state_q, state_d;
   fetch_addr_t addr_q;          // Address of the fetch in flight
   set_idx_t    fetch_idx;
   set_idx_t    flush_idx_q;     // Walk position, wraps back to zero
   logic        bypass_q;        // Fetch in flight was granted in bypass
   logic        flush_pend_q;    // Flush pulse waiting for IDLE
   logic        flush_go;
   line_t       hit_line;

   assign fetch_idx   = addr_q[OFFSET_W +: INDEX_W];
   assign fetch_tag_o = addr_q[OFFSET_W+INDEX_W +: TAG_W];
   assign flush_go    = flush_icache_i || flush_pend_q;

   // Refill always targets the whole line
   assign refill_addr_o       = '{tag: fetch_tag_o, idx: fetch_idx, offset: '0};
   assign data_wdata_o        = resp_data_i;
   assign tag_wdata_o         = (state_q == FLUSH) ? tag_entry_t'('0)
                                                   : tag_entry_t'{valid: 1'b1, tag: fetch_tag_o};
   assign cache_is_bypassed_o = (state_q == IDLE) && bypass_icache_i;

   // One-hot mux of the way data
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (hit_way_i[w])
         begin
            hit_line = hit_line | data_rdata_i[w];
         end
      end
   end

   ////////////////////////////////////////
   // Next state and bank accesses
   ////////////////////////////////////////

   always_comb
   begin
      state_d        = state_q;
      fetch_gnt_o    = 1'b0;
      fetch_rvalid_o = 1'b0;
      fetch_rdata_o  = resp_data_i;                 // Refill data unless a hit
      tag_acc_o      = '0;
      data_acc_o     = '0;
      refill_req_o   = 1'b0;
      refill_done_o  = 1'b0;

      case (state_q)
         FLUSH:
         begin
            tag_acc_o = '{req: '1, we: 1'b1, idx: flush_idx_q};  // Invalid tag in every way
            if (flush_idx_q == set_idx_t'(NB_SETS-1))
            begin
               state_d = IDLE;
            end
         end

         IDLE:
         begin
            if (flush_go)
            begin
               state_d = FLUSH;
            end
            else if (fetch_req_i)
            begin
               fetch_gnt_o = 1'b1;
               if (bypass_icache_i)
               begin
                  state_d = REFILL_REQ;                // No lookup in bypass
               end
               else
               begin
                  tag_acc_o  = '{req: '1, we: 1'b0, idx: fetch_addr_i[OFFSET_W +: INDEX_W]};
                  data_acc_o = '{req: '1, we: 1'b0, idx: fetch_addr_i[OFFSET_W +: INDEX_W]};
                  state_d    = LOOKUP;
               end
            end
         end

         LOOKUP:
         begin
            if (hit_i)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = hit_line;
               state_d        = IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;                    // Request the cycle after grant
               state_d      = refill_gnt_i ? REFILL_WAIT : REFILL_REQ;
            end
         end

         REFILL_REQ:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
            begin
               state_d = REFILL_WAIT;
            end
         end

         REFILL_WAIT:
         begin
            if (resp_valid_i)
            begin
               fetch_rvalid_o = 1'b1;
               state_d        = IDLE;
               if (!bypass_q)
               begin
                  tag_acc_o     = '{req: victim_way_i, we: 1'b1, idx: fetch_idx};
                  data_acc_o    = '{req: victim_way_i, we: 1'b1, idx: fetch_idx};
                  refill_done_o = 1'b1;
               end
            end
         end

         default: state_d = FLUSH;
      endcase
   end

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
      begin
         addr_q <= fetch_addr_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q            <= FLUSH;                  // Walk the sets out of reset
         flush_idx_q        <= '0;
         bypass_q           <= 1'b0;
         flush_pend_q       <= 1'b0;
         cache_is_flushed_o <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == FLUSH)
         begin
            flush_idx_q <= flush_idx_q + 1'b1;
         end
         if (fetch_gnt_o)
         begin
            bypass_q <= bypass_icache_i;
         end
         // IDLE consumes the pending flush
         if (state_q == IDLE)
         begin
            flush_pend_q <= 1'b0;
         end
         else if (flush_icache_i && (state_q != FLUSH))
         begin
            flush_pend_q <= 1'b1;
         end
         if ((state_q == FLUSH) && (state_d == IDLE))
         begin
            cache_is_flushed_o <= 1'b1;
         end
         else if ((state_d == FLUSH) || refill_done_o)
         begin
            cache_is_flushed_o <= 1'b0;                // First allocation dirties it
         end
      end
   end

   a_gnt_in_idle : assert property (
      @(posedge clk) disable iff (!arst_n_i) fetch_gnt_o |-> (state_q == IDLE)
   ) else $error("fetch grant outside IDLE");

endmodule

// ==== icache_refill_fifo.sv ====
////////////////////////////////////////
// Two lines deep, popped every cycle it holds data
////////////////////////////////////////

`timescale 1ns/1ps

module icache_refill_fifo (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  push_i,
   input  icache_cfg_pkg::line_t data_i,
   output logic                  valid_o,
   output icache_cfg_pkg::line_t data_o
);

   import icache_cfg_pkg::*;

   line_t      mem_q [2];
   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] cnt_q;      // Entries held, 0 to 2
   logic       pop;
   logic       full;

   assign valid_o = (cnt_q != 2'd0);
   assign pop     = valid_o;                  // Controller never stalls the head
   assign full    = (cnt_q == 2'd2);
   assign data_o  = mem_q[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (push_i)
      begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         cnt_q    <= 2'd0;
      end
      else
      begin
         if (push_i)
         begin
            wr_ptr_q <= ~wr_ptr_q;
         end
         if (pop)
         begin
            rd_ptr_q <= ~rd_ptr_q;
         end
         cnt_q <= cnt_q + 2'(push_i) - 2'(pop);
      end
   end

   // Refill side has no back-pressure, so overflow would lose a line
   a_no_overflow : assert property (
      @(posedge clk) disable iff (!arst_n_i) !(push_i && full)
   ) else $error("refill buffer pushed while full");

endmodule

// ==== icache_tag_compare.sv ====
////////////////////////////////////////
// Hit and victim are combinational on the registered bank tags
////////////////////////////////////////

`timescale 1ns/1ps

module icache_tag_compare (
   input  logic                                                    clk,
   input  logic                                                    arst_n_i,
   input  icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::NB_WAYS-1:0] tags_i,
   input  icache_cfg_pkg::tag_t                                    fetch_tag_i,
   input  logic                                                    refill_done_i,
   output logic                                                    hit_o,
   output icache_cfg_pkg::way_vec_t                                hit_way_o,
   output icache_cfg_pkg::way_vec_t                                victim_way_o
);

   import icache_cfg_pkg::*;

   way_vec_t rr_q;         // One-hot round-robin pointer
   way_vec_t invalid;      // Ways with a cleared valid bit
   way_vec_t first_inv;    // Lowest invalid way

   ////////////////////////////////////////
   // Tag match
   ////////////////////////////////////////

   always_comb
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         hit_way_o[w] = tags_i[w].valid && (tags_i[w].tag == fetch_tag_i);
         invalid[w]   = !tags_i[w].valid;
      end
   end

   assign hit_o = |hit_way_o;

   ////////////////////////////////////////
   // Victim choice
   ////////////////////////////////////////

   assign first_inv    = invalid & (~invalid + way_vec_t'(1));  // Isolate lowest set bit
   assign victim_way_o = (|invalid) ? first_inv : rr_q;          // Fill holes first

   // Moves on every refill write, whichever way it went to
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rr_q <= way_vec_t'(1);
      end
      else if (refill_done_i)
      begin
         rr_q <= {rr_q[NB_WAYS-2:0], rr_q[NB_WAYS-1]};  // Rotate left
      end
   end

   // A line is only allocated on a miss, so no set holds the same tag twice
   a_hit_onehot : assert property (
      @(posedge clk) disable iff (!arst_n_i) $onehot0(hit_way_o)
   ) else $error("tag hit in more than one way");

endmodule

// ==== icache_way_bank.sv ====
////////////////////////////////////////
// One way of tags or data, read data one cycle after rd_en_i
// Read and write in the same cycle is not supported
////////////////////////////////////////

`timescale 1ns/1ps

module icache_way_bank #(
   parameter int unsigned WIDTH = icache_cfg_pkg::LINE_W,
   parameter int unsigned DEPTH = icache_cfg_pkg::NB_SETS
) (
   input  logic                     clk,
   input  logic                     arst_n_i,
   input  logic                     rd_en_i,
   input  logic                     wr_en_i,
   input  icache_cfg_pkg::set_idx_t addr_i,
   input  logic [WIDTH-1:0]         wdata_i,
   output logic [WIDTH-1:0]         rdata_o
);

   logic [WIDTH-1:0] mem_q [DEPTH];   // One row per set

   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         mem_q[addr_i] <= wdata_i;
      end
   end

   // Read port, holds its value between reads
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rdata_o <= '0;                 // A tag reads as invalid before the first read
      end
      else if (rd_en_i)
      begin
         rdata_o <= mem_q[addr_i];
      end
   end

   // The controller never mixes a lookup read with a refill or flush write
   a_no_rd_wr : assert property (
      @(posedge clk) disable iff (!arst_n_i) !(rd_en_i && wr_en_i)
   ) else $error("way bank read and write in the same cycle");

endmodule

// ==== icache_bus_pkg.sv ====
////////////////////////////////////////
// Bank access, refill request and controller states
////////////////////////////////////////

package icache_bus_pkg;

   ////////////////////////////////////////
   // Bank access
   ////////////////////////////////////////

   // One access to the tag or data banks, about 7 bits
   typedef struct packed {
      icache_cfg_pkg::way_vec_t req;   // Ways addressed
      logic                     we;    // Write to all addressed ways
      icache_cfg_pkg::set_idx_t idx;   // Shared set index
   } way_access_t;

   ////////////////////////////////////////
   // Refill request
   ////////////////////////////////////////

   // Line-aligned refill address, same layout as a fetch address
   typedef struct packed {
      icache_cfg_pkg::tag_t                tag;
      icache_cfg_pkg::set_idx_t            idx;
      logic [icache_cfg_pkg::OFFSET_W-1:0] offset;  // Always zero
   } refill_req_t;

   ////////////////////////////////////////
   // Controller FSM
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      FLUSH,         // Invalidate walk, one set per cycle
      IDLE,          // Ready to grant
      LOOKUP,        // Tags and data back from the banks
      REFILL_REQ,    // Request held until granted
      REFILL_WAIT    // Waiting for the buffered response
   } ctrl_state_e;

endpackage

// ==== icache_cfg_pkg.sv ====
////////////////////////////////////////
// Geometry is fixed at 2 ways x 16 sets, one 128-bit fetch word per line
// Full tags only, so the tag is every address bit above the set index
////////////////////////////////////////

package icache_cfg_pkg;

   ////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////

   localparam int unsigned FETCH_ADDR_W = 32;              // Byte address from fetch
   localparam int unsigned LINE_W       = 128;             // Line and fetch word width
   localparam int unsigned NB_WAYS      = 2;               // Associativity
   localparam int unsigned NB_SETS      = 16;

   // Address split, low to high: offset, index, tag
   localparam int unsigned OFFSET_W     = $clog2(LINE_W/8); // 4
   localparam int unsigned INDEX_W      = $clog2(NB_SETS);  // 4
   localparam int unsigned TAG_W        = FETCH_ADDR_W - INDEX_W - OFFSET_W; // 24

   ////////////////////////////////////////
   // Widths with a meaning
   ////////////////////////////////////////

   typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;
   typedef logic [LINE_W-1:0]       line_t;
   typedef logic [INDEX_W-1:0]      set_idx_t;
   typedef logic [TAG_W-1:0]        tag_t;
   typedef logic [NB_WAYS-1:0]      way_vec_t;     // One bit per way

   // Stored tag with its valid flag, TAG_W+1 bits
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

endpackage
